// ==== source/fetch_cfg.svh ====
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// first pc after reset
// the instruction memory is based here too
`define FETCH_RESET_VEC 64'h8000_0000

// memory depth in 64-bit words
`define FETCH_IMEM_WORDS 256

// cycles from address transfer to rvalid
// must stay at 1 or more
`define FETCH_MEM_LAT 2

// bus address width
`define FETCH_AW 32

`endif

// ==== source/fetch_pkg.sv ====
`include "fetch_cfg.svh"

package fetch_pkg;

   // program counter and raw instruction word
   typedef logic [63:0] pc_t;
   typedef logic [31:0] inst_t;

   // read response codes
   typedef logic [1:0] rresp_t;
   localparam rresp_t RESP_OKAY   = 2'b00;
   localparam rresp_t RESP_SLVERR = 2'b10;

   // read address channel
   typedef struct packed {
      logic                 arvalid;
      logic [`FETCH_AW-1:0] araddr;
   } ar_req_t;

   // read data channel
   // rready is tied high so it has no field
   typedef struct packed {
      logic        rvalid;
      logic [63:0] rdata;
      rresp_t      rresp;
   } r_rsp_t;

   // one fetched instruction
   typedef struct packed {
      logic  valid;
      pc_t   pc;
      inst_t inst;
      logic  fault;
   } fetch_rec_t;

   // memory load strobe
   // addr is a byte address on a 4-byte boundary
   typedef struct packed {
      logic                 valid;
      logic [`FETCH_AW-1:0] addr;
      logic [31:0]          data;
   } load_t;

   // fetch unit states
   typedef enum logic [1:0] {
      IFU_IDLE,
      IFU_REQ,
      IFU_WAIT,
      IFU_HALT
   } ifu_state_t;

endpackage

// ==== source/next_pc.sv ====
module next_pc
   import fetch_pkg::*;
(
   input  pc_t   pc,
   input  inst_t inst,
   output pc_t   dnpc
);

   // jal major opcode
   localparam logic [6:0] OP_JAL = 7'b1101111;

   // sequential step in bytes
   localparam pc_t STEP_SEQ = 64'd4;

   logic        is_jal;
   logic        sign;
   logic [7:0]  imm_19_12;
   logic        imm_11;
   logic [9:0]  imm_10_1;
   pc_t         imm_j;
   pc_t         step;

   assign is_jal = (inst[6:0] == OP_JAL);

   // j-type immediate fields
   // bit 0 is always zero
   assign sign      = inst[31];
   assign imm_19_12 = inst[19:12];
   assign imm_11    = inst[20];
   assign imm_10_1  = inst[30:21];

   // sign-extend from bit 20
   assign imm_j = {
      {43{sign}},
      sign,
      imm_19_12,
      imm_11,
      imm_10_1,
      1'b0
   };

   // jump offset or plain step
   assign step = is_jal ? imm_j : STEP_SEQ;

   // wraps at 64 bits
   assign dnpc = pc + step;

endmodule

// ==== source/imem.sv ====
`include "fetch_cfg.svh"

module imem
   import fetch_pkg::*;
(
   input  logic    clk,
   input  logic    rst_n,
   input  load_t   load,
   input  ar_req_t ar,
   output logic    arready,
   output r_rsp_t  r
);

   localparam int AW    = `FETCH_AW;
   localparam int WORDS = `FETCH_IMEM_WORDS;
   localparam int LAT   = `FETCH_MEM_LAT;
   localparam int IDX_W = (WORDS > 1) ? $clog2(WORDS) : 1;
   localparam int CNT_W = (LAT > 1) ? $clog2(LAT) : 1;

   localparam logic [63:0]      RESET_VEC = `FETCH_RESET_VEC;
   localparam logic [AW-1:0]    BASE      = RESET_VEC[AW-1:0];
   localparam logic [AW-1:0]    SPAN      = AW'(WORDS * 8);
   localparam logic [CNT_W-1:0] CNT_INIT  = CNT_W'(LAT - 1);

   // below-base addresses wrap to a huge offset
   function automatic logic in_range(input logic [AW-1:0] addr);
      logic [AW-1:0] off;
      off = addr - BASE;
      return off < SPAN;
   endfunction

   // 64-bit word index from a byte address
   function automatic logic [IDX_W-1:0] word_idx(input logic [AW-1:0] addr);
      logic [AW-1:0] off;
      off = addr - BASE;
      return off[3 +: IDX_W];
   endfunction

   logic [63:0] mem [WORDS];

   // one read outstanding at most
   logic             busy;
   logic [CNT_W-1:0] cnt;
   logic [63:0]      rdata_q;
   rresp_t           rresp_q;

   logic             accept;
   logic             rvalid;
   logic             load_hit;
   logic [IDX_W-1:0] load_idx;
   logic [IDX_W-1:0] rd_idx;

   assign arready  = !busy;
   assign accept   = ar.arvalid && arready;
   // response in the cycle the countdown hits zero
   assign rvalid   = busy && (cnt == '0);
   // out of range loads are dropped
   assign load_hit = load.valid && in_range(load.addr);
   assign load_idx = word_idx(load.addr);
   assign rd_idx   = word_idx(ar.araddr);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         busy <= 1'b0;
         cnt  <= '0;
      end else if (accept) begin
         busy <= 1'b1;
         cnt  <= CNT_INIT;
      end else if (rvalid) begin
         busy <= 1'b0;
      end else if (busy) begin
         cnt <= cnt - 1'b1;
      end
   end

   // array and read data
   // word sampled at the transfer edge
   always_ff @(posedge clk) begin
      if (load_hit) begin
         if (load.addr[2]) begin
            mem[load_idx][63:32] <= load.data;
         end else begin
            mem[load_idx][31:0] <= load.data;
         end
      end
      if (accept) begin
         if (in_range(ar.araddr)) begin
            rdata_q <= mem[rd_idx];
            rresp_q <= RESP_OKAY;
         end else begin
            rdata_q <= '0;
            rresp_q <= RESP_SLVERR;
         end
      end
   end

   assign r = '{rvalid: rvalid, rdata: rdata_q, rresp: rresp_q};

endmodule

// ==== source/ifu.sv ====
`include "fetch_cfg.svh"

module ifu
   import fetch_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  logic       hold,
   output ar_req_t    ar,
   input  logic       arready,
   input  r_rsp_t     r,
   input  pc_t        dnpc,
   output fetch_rec_t fetch_rec
);

   localparam int AW = `FETCH_AW;

   ifu_state_t state;

   // pc of the fetch in flight or next to go
   pc_t pc;

   // request register
   logic          arvalid_q;
   logic [AW-1:0] araddr_q;

   // record register
   logic  rec_valid_q;
   pc_t   rec_pc_q;
   inst_t rec_inst_q;
   logic  rec_fault_q;

   // dnpc only means something while the record is out
   pc_t   fetch_pc;
   logic  resp_err;
   inst_t inst_sel;
   logic  issue;
   logic  resp_done;

   assign fetch_pc  = rec_valid_q ? dnpc : pc;
   assign resp_err  = (r.rresp != RESP_OKAY);
   assign issue     = (state == IFU_IDLE) && !hold;
   assign resp_done = (state == IFU_WAIT) && r.rvalid;

   // upper half for addresses with bit 2 set
   // error responses deliver zero
   assign inst_sel = resp_err ? '0 :
                     (araddr_q[2] ? r.rdata[63:32] : r.rdata[31:0]);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state       <= IFU_IDLE;
         pc          <= `FETCH_RESET_VEC;
         arvalid_q   <= 1'b0;
         rec_valid_q <= 1'b0;
      end else begin
         // record is a one-cycle strobe
         rec_valid_q <= 1'b0;
         // step the pc at the end of the record cycle
         if (rec_valid_q) begin
            pc <= dnpc;
         end
         case (state)
            IFU_IDLE: begin
               // hold only blocks new requests
               if (!hold) begin
                  arvalid_q <= 1'b1;
                  state     <= IFU_REQ;
               end
            end
            IFU_REQ: begin
               // arvalid stays up until the transfer
               if (arready) begin
                  arvalid_q <= 1'b0;
                  state     <= IFU_WAIT;
               end
            end
            IFU_WAIT: begin
               if (r.rvalid) begin
                  rec_valid_q <= 1'b1;
                  state       <= resp_err ? IFU_HALT : IFU_IDLE;
               end
            end
            IFU_HALT: begin
               // stuck here until reset
               state <= IFU_HALT;
            end
            default: begin
               state <= IFU_IDLE;
            end
         endcase
      end
   end

   // payload side
   always_ff @(posedge clk) begin
      if (issue) begin
         araddr_q <= fetch_pc[AW-1:0];
      end
      if (resp_done) begin
         rec_pc_q    <= pc;
         rec_inst_q  <= inst_sel;
         rec_fault_q <= resp_err;
      end
   end

   assign ar = '{arvalid: arvalid_q, araddr: araddr_q};

   assign fetch_rec = '{
      valid: rec_valid_q,
      pc:    rec_pc_q,
      inst:  rec_inst_q,
      fault: rec_fault_q
   };

endmodule

// ==== source/fetch_top.sv ====
module fetch_top
   import fetch_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  logic       hold,
   input  load_t      load,
   output fetch_rec_t fetch_rec
);

   // read address channel
   ar_req_t ar;
   logic    arready;

   // read data channel
   r_rsp_t  r;

   // next fetch address from the current record
   pc_t     dnpc;

   // fetch unit
   // owns the pc and the bus master side
   ifu u_ifu (
      .clk       (clk),
      .rst_n     (rst_n),
      .hold      (hold),
      .ar        (ar),
      .arready   (arready),
      .r         (r),
      .dnpc      (dnpc),
      .fetch_rec (fetch_rec)
   );

   // jal target or pc plus 4
   next_pc u_next_pc (
      .pc   (fetch_rec.pc),
      .inst (fetch_rec.inst),
      .dnpc (dnpc)
   );

   // instruction memory
   // read slave plus load port
   imem u_imem (
      .clk     (clk),
      .rst_n   (rst_n),
      .load    (load),
      .ar      (ar),
      .arready (arready),
      .r       (r)
   );

endmodule

// ==== dv/fetch_properties.sv ====
module fetch_properties
   import fetch_pkg::*;
(
   input logic       clk,
   input logic       rst_n,
   input ar_req_t    ar,
   input logic       arready,
   input r_rsp_t     r,
   input fetch_rec_t fetch_rec
);

   // failed assertions so far, polled by the testbench
   int unsigned fail_count;

   // read accepted and not yet answered
   logic outstanding;

   initial fail_count = 0;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         outstanding <= 1'b0;
      end else if (ar.arvalid && arready) begin
         outstanding <= 1'b1;
      end else if (r.rvalid) begin
         outstanding <= 1'b0;
      end
   end

   // request held steady until the transfer
   ar_stable: assert property (
      @(posedge clk) disable iff (!rst_n)
      ar.arvalid && !arready |=> ar.arvalid && $stable(ar.araddr)
   ) else begin
      $error("arvalid or araddr changed before arready");
      fail_count++;
   end

   // first cycle out of reset
   reset_quiet: assert property (
      @(posedge clk) $rose(rst_n) |-> !ar.arvalid && !fetch_rec.valid
   ) else begin
      $error("arvalid or fetch_rec.valid high right after reset");
      fail_count++;
   end

   // no response without a request in flight
   r_after_ar: assert property (
      @(posedge clk) disable iff (!rst_n)
      r.rvalid |-> outstanding
   ) else begin
      $error("rvalid with no read outstanding");
      fail_count++;
   end

endmodule

bind ifu fetch_properties u_props (
   .clk       (clk),
   .rst_n     (rst_n),
   .ar        (ar),
   .arready   (arready),
   .r         (r),
   .fetch_rec (fetch_rec)
);

// ==== dv/fetch_tb.sv ====
`include "fetch_cfg.svh"

module fetch_tb
   import fetch_pkg::*;
();

   localparam pc_t        BASE         = `FETCH_RESET_VEC;
   localparam int         HALVES       = `FETCH_IMEM_WORDS * 2;
   localparam pc_t        LIMIT        = BASE + pc_t'(HALVES * 4);
   localparam int         REC_TIMEOUT  = 1000;
   localparam int         QUIET_CYCLES = 200;
   localparam logic [6:0] JAL_OP       = 7'b1101111;

   logic       clk;
   logic       rst_n;
   logic       hold;
   load_t      load;
   fetch_rec_t fetch_rec;

   // lfsr state stepped once per random bit
   logic [31:0] lfsr;

   // reference copy of memory with one entry per 32-bit half
   inst_t model_mem [HALVES];
   pc_t   model_pc;

   logic hold_random;
   logic fault_seen;
   // records seen in the current hold-high window
   int   hold_recs;

   fetch_top u_dut (
      .clk       (clk),
      .rst_n     (rst_n),
      .hold      (hold),
      .load      (load),
      .fetch_rec (fetch_rec)
   );

   initial clk = 1'b0;
   always #5 clk = ~clk;

   // galois form with taps 32 30 26 25
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 32'hA300_0000;
      end
      return s >> 1;
   endfunction

   function automatic logic [31:0] draw_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   // offset in bytes as a multiple of 4
   function automatic inst_t jal_word(input int offset, input logic [4:0] rd);
      logic [20:0] imm;
      imm = 21'(offset);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, JAL_OP};
   endfunction

   // jal target or the next sequential word
   function automatic pc_t model_next(input pc_t pc, input inst_t inst);
      logic [20:0]        imm;
      logic signed [63:0] off;
      if (inst[6:0] != JAL_OP) begin
         return pc + 64'd4;
      end
      imm = {inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
      off = $signed(imm);
      return pc + pc_t'(off);
   endfunction

   // outside the memory means slverr and a zero word
   task automatic model_fetch(input pc_t pc, output inst_t inst, output logic fault);
      if (pc < BASE || pc >= LIMIT) begin
         inst  = '0;
         fault = 1'b1;
      end else begin
         inst  = model_mem[int'((pc - BASE) >> 2)];
         fault = 1'b0;
      end
   endtask

   task automatic stop_on_error();
      $display("ERRORS FOUND");
      $fatal(1, "stopping at the first error");
   endtask

   task automatic report_failure(input string what);
      $display("failure at time %0t: %s", $time, what);
      stop_on_error();
   endtask

   task automatic compare_pc(input string name, input pc_t got, input pc_t exp);
      if (got !== exp) begin
         $display("** Error: %s got %h expected %h", name, got, exp);
         stop_on_error();
      end
   endtask

   task automatic compare_inst(input string name, input inst_t got, input inst_t exp);
      if (got !== exp) begin
         $display("** Error: %s got %h expected %h", name, got, exp);
         stop_on_error();
      end
   endtask

   task automatic compare_fault(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("** Error: %s got %h expected %h", name, got, exp);
         stop_on_error();
      end
   endtask

   // one clock where hold may flip during the random run
   task automatic tick();
      @(posedge clk);
      if (hold_random && draw_bits(3) == 0) begin
         hold <= ~hold;
      end
      @(negedge clk);
   endtask

   task automatic set_hold(input logic v);
      @(posedge clk);
      hold <= v;
      @(negedge clk);
   endtask

   // three cycles low
   task automatic apply_reset();
      @(posedge clk);
      rst_n <= 1'b0;
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
   endtask

   // one write strobe per 32-bit half
   task automatic load_half(input int idx, input inst_t data);
      @(posedge clk);
      load <= '{valid: 1'b1, addr: BASE[`FETCH_AW-1:0] + `FETCH_AW'(idx * 4), data: data};
      @(posedge clk);
      load <= '0;
      model_mem[idx] = data;
   endtask

   // about one jal in eight
   task automatic load_program();
      inst_t      w;
      int         off;
      logic [6:0] steps;
      for (int i = 0; i < HALVES; i++) begin
         if (draw_bits(3) == 0) begin
            // up to 64 instructions either way
            steps = 7'(draw_bits(7));
            off   = 4 * int'($signed(steps));
            w     = jal_word(off, 5'(draw_bits(5)));
         end else begin
            w = draw_bits(32);
            // keep random words off the jal opcode
            if (w[6:0] == JAL_OP) begin
               w[3] = ~w[3];
            end
         end
         load_half(i, w);
      end
   endtask

   task automatic wait_record();
      int cycles;
      cycles = 0;
      while (!fetch_rec.valid) begin
         if (cycles == REC_TIMEOUT) begin
            report_failure("no fetch record arrived before the timeout");
         end else begin
            tick();
            cycles++;
         end
      end
   endtask

   // halted ifu must stay silent with hold low
   task automatic expect_quiet();
      for (int i = 0; i < QUIET_CYCLES; i++) begin
         tick();
         if (fetch_rec.valid) begin
            report_failure("a fetch record arrived after a faulted fetch");
         end
      end
   endtask

   task automatic run_records(input int count);
      inst_t exp_inst;
      logic  exp_fault;
      int    n;
      n          = 0;
      fault_seen = 1'b0;
      while (n < count && !fault_seen) begin
         wait_record();
         model_fetch(model_pc, exp_inst, exp_fault);
         compare_pc("fetch_rec.pc", fetch_rec.pc, model_pc);
         compare_inst("fetch_rec.inst", fetch_rec.inst, exp_inst);
         compare_fault("fetch_rec.fault", fetch_rec.fault, exp_fault);
         model_pc   = model_next(model_pc, exp_inst);
         fault_seen = exp_fault;
         n++;
         tick();
      end
      if (fault_seen) begin
         hold_random = 1'b0;
         set_hold(1'b0);
         expect_quiet();
      end
   endtask

   // at most one record per hold-high window
   always @(negedge clk) begin
      if (!rst_n || !hold) begin
         hold_recs = 0;
      end else if (fetch_rec.valid) begin
         hold_recs++;
         if (hold_recs > 1) begin
            report_failure("more than one fetch record while hold was high");
         end
      end
      if (u_dut.u_ifu.u_props.fail_count != 0) begin
         report_failure("a bus assertion failed");
      end
   end

   initial begin
      inst_t saved;
      lfsr        = 32'h67fd;
      hold_random = 1'b0;
      fault_seen  = 1'b0;
      model_pc    = BASE;
      rst_n       = 1'b0;
      hold        = 1'b1;
      load        = '0;
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);

      // random program loaded while fetch is held off
      load_program();
      model_pc    = BASE;
      hold_random = 1'b1;
      set_hold(1'b0);
      run_records(400);

      // jump below the memory from the reset vector
      hold_random = 1'b0;
      set_hold(1'b1);
      saved = model_mem[0];
      apply_reset();
      load_half(0, jal_word(-8, 5'd1));
      model_pc = BASE;
      set_hold(1'b0);
      run_records(4);
      if (!fault_seen) begin
         report_failure("the out-of-range fetch gave no faulted record");
      end

      // fresh reset restarts at the reset vector
      set_hold(1'b1);
      load_half(0, saved);
      apply_reset();
      model_pc    = BASE;
      hold_random = 1'b1;
      set_hold(1'b0);
      run_records(60);

      if (u_dut.u_ifu.u_props.fail_count == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

// ==== sim.f ====
+incdir+source
source/fetch_pkg.sv
source/next_pc.sv
source/imem.sv
source/ifu.sv
source/fetch_top.sv
dv/fetch_properties.sv
dv/fetch_tb.sv

// ==== Bender.yml ====
package:
  name: fetch_front

sources:
  - include_dirs:
      - source
    files:
      - source/fetch_pkg.sv
      - source/next_pc.sv
      - source/imem.sv
      - source/ifu.sv
      - source/fetch_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - dv/fetch_properties.sv
      - dv/fetch_tb.sv
